/* common/conv_pkg.sv */
package conv_pkg;

    // adc stream geometry
    // eight samples per beat, one beat per aclk
    localparam int n_samp = 8;
    localparam int adc_bits = 16;

    // top bits kept by the capture lanes
    localparam int keep_bits = 12;

    // low sample bits thrown away by compression
    localparam int drop_bits = adc_bits - keep_bits;

    // full beat width, 128
    localparam int beat_bits = n_samp * adc_bits;

    // dense packing uses only the low 96 bits of a word
    localparam int dense_bits = n_samp * keep_bits;

    // capture lane buffer depth
    // equals the input credits a source owns after reset
    localparam int lane_depth = 4;

    // lane pointer and occupancy widths
    localparam int ptr_bits = $clog2(lane_depth);
    localparam int cnt_bits = $clog2(lane_depth + 1);

    // dac beats the packer may send before any credit comes back
    localparam int out_credits = 2;

    // width of the packer credit counter, holds 0 .. out_credits
    localparam int ocred_bits = $clog2(out_credits + 1);

    // one adc sample, two's complement, msb aligned
    typedef logic [adc_bits-1:0] sample_t;

    // raw adc beat
    // samp[0] sits in bits 15:0
    typedef struct packed {
        sample_t [n_samp-1:0] samp;
    } adc_beat_t;

    // compressed lane word
    // dense mode: sample i at bits i*12 +: 12, top 32 bits zero
    // lsb mode: sample i at bits i*16 +: 12, four zero bits above it
    typedef struct packed {
        logic [beat_bits-1:0] word;
    } packed_beat_t;

    // dac beat, channel 0 in the low half
    typedef struct packed {
        adc_beat_t hi;
        adc_beat_t lo;
    } dac_beat_t;

    // storage format of a capture lane
    typedef enum logic {
        PACK_DENSE = 1'b0,
        PACK_LSB   = 1'b1
    } pack_mode_e;

    // packer output stage
    // PK_SEND marks a registered dac beat on the output
    typedef enum logic {
        PK_IDLE = 1'b0,
        PK_SEND = 1'b1
    } packer_state_e;

endpackage

/* design/capture_lane.sv */
`timescale 1ns/1ps

module capture_lane #(
    parameter conv_pkg::pack_mode_e mode = conv_pkg::PACK_DENSE
) (
    input  logic                   aclk,
    input  logic                   rst,
    input  conv_pkg::adc_beat_t    in_beat,
    input  logic                   in_valid,
    output logic                   credit,
    output conv_pkg::packed_beat_t head,
    output logic                   avail,
    input  logic                   take
);

    import conv_pkg::*;

    // compress one beat to keep_bits per sample
    // the low drop_bits of every sample are discarded
    function automatic packed_beat_t compress(adc_beat_t b, pack_mode_e m);
        packed_beat_t w;
        for (int i = 0; i < n_samp; i++)
        begin
            if (m == PACK_DENSE)
            begin
                // back to back 12 bits apart
                w.word[i*keep_bits +: keep_bits] = b.samp[i][adc_bits-1:drop_bits];
            end
            else
            begin
                // one per 16 bit slot with zero padding on top
                w.word[i*adc_bits +: adc_bits] =
                    {{drop_bits{1'b0}}, b.samp[i][adc_bits-1:drop_bits]};
            end
        end
        // dense words leave the top bits clear
        if (m == PACK_DENSE)
        begin
            w.word[beat_bits-1:dense_bits] = '0;
        end
        return w;
    endfunction

    // circular buffer
    packed_beat_t         mem [lane_depth];
    logic [ptr_bits-1:0]  wr_ptr;
    logic [ptr_bits-1:0]  rd_ptr;
    logic [cnt_bits-1:0]  count;

    packed_beat_t comp;
    logic         push;
    logic         pop;

    // compressed form of the incoming beat
    assign comp = compress(in_beat, mode);

    // a sender only drives valid while it holds a credit
    // so a push always finds a free entry
    assign push = in_valid;

    // an entry leaves only when it is actually there
    assign pop = take && avail;

    // oldest entry is visible to the packer straight from the buffer
    assign head  = mem[rd_ptr];
    assign avail = (count != '0);

    // payload storage
    always_ff @(posedge aclk)
    begin
        if (push)
        begin
            mem[wr_ptr] <= comp;
        end
    end

    // pointers and occupancy
    always_ff @(posedge aclk)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            // pointers wrap on their own since depth is a power of two
            if (push)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            unique case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // one credit back per freed entry
    // high for the cycle after the pop edge
    always_ff @(posedge aclk)
    begin
        if (rst)
        begin
            credit <= 1'b0;
        end
        else
        begin
            credit <= pop;
        end
    end

endmodule

/* design/dac_pair_packer.sv */
`timescale 1ns/1ps

module dac_pair_packer (
    input  logic                   aclk,
    input  logic                   rst,
    input  conv_pkg::packed_beat_t lane0_head,
    input  conv_pkg::packed_beat_t lane1_head,
    input  logic                   lane0_avail,
    input  logic                   lane1_avail,
    output logic                   take,
    output conv_pkg::dac_beat_t    dac_beat,
    output logic                   dac_valid,
    input  logic                   dac_credit
);

    import conv_pkg::*;

    // rebuild msb aligned 16 bit samples from a lane word
    // the 12 kept bits go on top, zeros fill the low bits
    function automatic adc_beat_t unpack(packed_beat_t w, pack_mode_e m);
        adc_beat_t b;
        logic [keep_bits-1:0] s;
        b = '0;
        for (int i = 0; i < n_samp; i++)
        begin
            if (m == PACK_DENSE)
            begin
                s = w.word[i*keep_bits +: keep_bits];
            end
            else
            begin
                // lsb aligned inside its 16 bit slot
                s = w.word[i*adc_bits +: keep_bits];
            end
            b.samp[i] = {s, {drop_bits{1'b0}}};
        end
        return b;
    endfunction

    // output credit counter
    logic [ocred_bits-1:0] cred;

    // output stage state
    packer_state_e state;

    // unpacked heads
    adc_beat_t beat0;
    adc_beat_t beat1;

    // lane 0 stores dense, lane 1 stores lsb aligned
    assign beat0 = unpack(lane0_head, PACK_DENSE);
    assign beat1 = unpack(lane1_head, PACK_LSB);

    // joint pop of both lanes
    // needs both heads and at least one output credit
    assign take = lane0_avail && lane1_avail && (cred != '0);

    // registered beat goes out in PK_SEND
    assign dac_valid = (state == PK_SEND);

    // credit is spent at the take edge, one cycle ahead of dac_valid
    always_ff @(posedge aclk)
    begin
        if (rst)
        begin
            cred <= out_credits[ocred_bits-1:0];
        end
        else
        begin
            unique case ({dac_credit, take})
                2'b10:   cred <= cred + 1'b1;
                2'b01:   cred <= cred - 1'b1;
                default: cred <= cred;
            endcase
        end
    end

    // one send cycle per take
    // back to back takes keep the state in PK_SEND
    always_ff @(posedge aclk)
    begin
        if (rst)
        begin
            state <= PK_IDLE;
        end
        else if (take)
        begin
            state <= PK_SEND;
        end
        else
        begin
            state <= PK_IDLE;
        end
    end

    // payload register
    // channel 0 low half, channel 1 high half
    always_ff @(posedge aclk)
    begin
        if (take)
        begin
            dac_beat.lo <= beat0;
            dac_beat.hi <= beat1;
        end
    end

endmodule

/* design/rf_loopback_top.sv */
`timescale 1ns/1ps

module rf_loopback_top (
    input  logic                aclk,
    input  logic                rst,
    input  conv_pkg::adc_beat_t adc0_beat,
    input  conv_pkg::adc_beat_t adc1_beat,
    input  logic                adc0_valid,
    input  logic                adc1_valid,
    output logic                adc0_credit,
    output logic                adc1_credit,
    output conv_pkg::dac_beat_t dac_beat,
    output logic                dac_valid,
    input  logic                dac_credit
);

    import conv_pkg::*;

    // lane heads toward the packer
    packed_beat_t lane0_head;
    packed_beat_t lane1_head;
    logic         lane0_avail;
    logic         lane1_avail;

    // single take, both lanes pop together
    logic take;

    // channel 0, dense 96 bit storage
    capture_lane #(
        .mode (PACK_DENSE)
    ) lane0 (
        .aclk     (aclk),
        .rst      (rst),
        .in_beat  (adc0_beat),
        .in_valid (adc0_valid),
        .credit   (adc0_credit),
        .head     (lane0_head),
        .avail    (lane0_avail),
        .take     (take)
    );

    // channel 1, one sample per 16 bit slot
    capture_lane #(
        .mode (PACK_LSB)
    ) lane1 (
        .aclk     (aclk),
        .rst      (rst),
        .in_beat  (adc1_beat),
        .in_valid (adc1_valid),
        .credit   (adc1_credit),
        .head     (lane1_head),
        .avail    (lane1_avail),
        .take     (take)
    );

    // pairs the two lanes into one dac beat
    dac_pair_packer packer (
        .aclk        (aclk),
        .rst         (rst),
        .lane0_head  (lane0_head),
        .lane1_head  (lane1_head),
        .lane0_avail (lane0_avail),
        .lane1_avail (lane1_avail),
        .take        (take),
        .dac_beat    (dac_beat),
        .dac_valid   (dac_valid),
        .dac_credit  (dac_credit)
    );

endmodule

/* verif/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic aclk
);

    // 40 ns period, rising edges at 20, 60, 100 ...
    initial
    begin
        aclk = 1'b0;
        forever
        begin
            #20 aclk = ~aclk;
        end
    end

endmodule

/* verif/rf_loopback_properties.sv */
`timescale 1ns/1ps

module rf_loopback_properties (
    input logic                aclk,
    input logic                rst,
    input conv_pkg::adc_beat_t adc0_beat,
    input conv_pkg::adc_beat_t adc1_beat,
    input logic                adc0_valid,
    input logic                adc1_valid,
    input logic                adc0_credit,
    input logic                adc1_credit,
    input conv_pkg::dac_beat_t dac_beat,
    input logic                dac_valid,
    input logic                dac_credit
);

    import conv_pkg::*;

    // accepted input beats per channel in arrival order
    adc_beat_t q0 [$];
    adc_beat_t q1 [$];

    // event counts up to the previous edge
    int acc0 = 0;
    int acc1 = 0;
    int cred0 = 0;
    int cred1 = 0;
    int sent = 0;
    int dcred = 0;

    // last dac beat and the input pair it should carry
    logic      chk;
    dac_beat_t exp_beat;
    dac_beat_t got_beat;

    // a beat has been accepted on this channel
    logic seen0;
    logic seen1;

    // bumped by every failing assertion below
    int assert_fails = 0;

    // input beat as it should come back with the low 4 bits cleared
    function automatic adc_beat_t truncated(adc_beat_t b);
        adc_beat_t t;
        t = b;
        for (int i = 0; i < n_samp; i++)
        begin
            t.samp[i][drop_bits-1:0] = '0;
        end
        return t;
    endfunction

    always_ff @(posedge aclk)
    begin
        if (rst)
        begin
            q0.delete();
            q1.delete();
            chk      <= 1'b0;
            exp_beat <= '0;
            got_beat <= '0;
            seen0    <= 1'b0;
            seen1    <= 1'b0;
        end
        else
        begin
            // compare before pushing so beats accepted at this edge stay out of it
            chk <= dac_valid && (q0.size() != 0) && (q1.size() != 0);
            if (dac_valid && (q0.size() != 0) && (q1.size() != 0))
            begin
                got_beat    <= dac_beat;
                exp_beat.lo <= truncated(q0[0]);
                exp_beat.hi <= truncated(q1[0]);
                void'(q0.pop_front());
                void'(q1.pop_front());
            end
            if (adc0_valid)
            begin
                q0.push_back(adc0_beat);
            end
            if (adc1_valid)
            begin
                q1.push_back(adc1_beat);
            end
            acc0  <= acc0 + int'(adc0_valid);
            acc1  <= acc1 + int'(adc1_valid);
            cred0 <= cred0 + int'(adc0_credit);
            cred1 <= cred1 + int'(adc1_credit);
            sent  <= sent + int'(dac_valid);
            dcred <= dcred + int'(dac_credit);
            seen0 <= seen0 || adc0_valid;
            seen1 <= seen1 || adc1_valid;
        end
    end

    // outputs quiet in the first cycle after reset
    reset_quiet: assert property (@(posedge aclk)
        $fell(rst) |-> !dac_valid && !adc0_credit && !adc1_credit)
        else
        begin
            $error("dac_valid or an adc credit high right after reset");
            assert_fails++;
        end

    // no dac beat before both channels delivered one
    no_early_valid: assert property (@(posedge aclk) disable iff (rst)
        dac_valid |-> seen0 && seen1)
        else
        begin
            $error("dac_valid before both channels had a beat accepted");
            assert_fails++;
        end

    // nth dac beat holds the nth beat of each channel truncated to 12 bits
    beat_matches: assert property (@(posedge aclk) disable iff (rst)
        chk |-> got_beat == exp_beat)
        else
        begin
            $error("CHECK FAILED beat_matches expected %h actual %h",
                $sampled(exp_beat), $sampled(got_beat));
            assert_fails++;
        end

    // output credit bound holds through the stalls too
    out_credit_bound: assert property (@(posedge aclk) disable iff (rst)
        sent + int'(dac_valid) <= out_credits + dcred)
        else
        begin
            $error("more dac beats sent than output credits allow");
            assert_fails++;
        end

    // a lane never frees more entries than it accepted
    in_credit_bound: assert property (@(posedge aclk) disable iff (rst)
        cred0 + int'(adc0_credit) <= acc0 && cred1 + int'(adc1_credit) <= acc1)
        else
        begin
            $error("a lane returned more credits than beats it accepted");
            assert_fails++;
        end

endmodule

/* verif/rf_loopback_tb.sv */
`timescale 1ns/1ps

module rf_loopback_tb;

    import conv_pkg::*;

    // beats per channel
    localparam int n_beats = 200;

    // roughly 1000 cycles with gaps and stalls, four times that as the limit
    localparam int timeout_cycles = 4000;

    // dac credits: prompt at first, then stall and release windows
    localparam int prompt_cycles = 300;
    localparam int stall_cycles = 150;
    localparam int release_cycles = 100;

    logic      aclk;
    logic      rst;
    adc_beat_t adc0_beat;
    adc_beat_t adc1_beat;
    logic      adc0_valid;
    logic      adc1_valid;
    logic      adc0_credit;
    logic      adc1_credit;
    dac_beat_t dac_beat;
    logic      dac_valid;
    logic      dac_credit;

    logic [31:0] lfsr = 32'ha736;

    // credits held toward each lane
    int cred0 = lane_depth;
    int cred1 = lane_depth;
    int sent0 = 0;
    int sent1 = 0;
    // dac beats seen and their credits not yet returned
    int rcvd = 0;
    int owed = 0;
    int cycle = 0;
    int errors = 0;

    tb_clock clock_gen (
        .aclk (aclk)
    );

    rf_loopback_top rf_loopback_top_inst (.*);

    bind rf_loopback_top rf_loopback_properties props (
        .aclk        (aclk),
        .rst         (rst),
        .adc0_beat   (adc0_beat),
        .adc1_beat   (adc1_beat),
        .adc0_valid  (adc0_valid),
        .adc1_valid  (adc1_valid),
        .adc0_credit (adc0_credit),
        .adc1_credit (adc1_credit),
        .dac_beat    (dac_beat),
        .dac_valid   (dac_valid),
        .dac_credit  (dac_credit)
    );

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // n fresh bits, one step each
    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic random_beat(output adc_beat_t b);
        logic [31:0] v;
        for (int i = 0; i < n_samp; i++)
        begin
            draw_bits(adc_bits, v);
            b.samp[i] = v[adc_bits-1:0];
        end
    endtask

    // three cycles in four, only with a credit in hand
    task automatic want_send(input int cred, input int sent, output logic go);
        logic [31:0] v;
        draw_bits(2, v);
        go = (cred > 0) && (sent < n_beats) && (v[1:0] != 2'b00);
    endtask

    function automatic logic credit_stalled(int c);
        return (c >= prompt_cycles)
            && (((c - prompt_cycles) % (stall_cycles + release_cycles)) < stall_cycles);
    endfunction

    function automatic logic all_drained();
        return sent0 == n_beats && sent1 == n_beats && rcvd == n_beats && owed == 0
            && cred0 == lane_depth && cred1 == lane_depth;
    endfunction

    task automatic check_total(input string name, input int expected, input int actual);
        if (expected != actual)
        begin
            $display("CHECK FAILED %s expected %0d actual %0d", name, expected, actual);
            errors++;
        end
    endtask

    initial
    begin
        logic        go;
        adc_beat_t   b;
        logic [31:0] v;
        int          fails;
        rst        = 1'b1;
        adc0_beat  = '0;
        adc1_beat  = '0;
        adc0_valid = 1'b0;
        adc1_valid = 1'b0;
        dac_credit = 1'b0;
        repeat (2) @(posedge aclk);
        rst <= 1'b0;

        while (!all_drained() && cycle < timeout_cycles)
        begin
            @(posedge aclk);
            cycle++;
            // sampled values belong to the cycle that just ended
            cred0 += int'(adc0_credit);
            cred1 += int'(adc1_credit);
            if (dac_valid)
            begin
                rcvd++;
                owed++;
            end
            want_send(cred0, sent0, go);
            if (go)
            begin
                random_beat(b);
                adc0_beat <= b;
                cred0--;
                sent0++;
            end
            adc0_valid <= go;
            want_send(cred1, sent1, go);
            if (go)
            begin
                random_beat(b);
                adc1_beat <= b;
                cred1--;
                sent1++;
            end
            adc1_valid <= go;
            // long stalls let both lanes fill up
            draw_bits(2, v);
            if (!credit_stalled(cycle) && owed > 0 && v[1:0] != 2'b00)
            begin
                dac_credit <= 1'b1;
                owed--;
            end
            else
            begin
                dac_credit <= 1'b0;
            end
        end

        @(posedge aclk);
        adc0_valid <= 1'b0;
        adc1_valid <= 1'b0;
        dac_credit <= 1'b0;
        repeat (2) @(posedge aclk);

        if (!all_drained())
        begin
            $display("timeout: streams not drained after %0d cycles", cycle);
            errors++;
        end
        check_total("adc0_beats_in", n_beats, sent0);
        check_total("adc1_beats_in", n_beats, sent1);
        check_total("dac_beats_out", n_beats, rcvd);
        check_total("adc0_credits_home", lane_depth, cred0);
        check_total("adc1_credits_home", lane_depth, cred1);

        fails = rf_loopback_top_inst.props.assert_fails;
        $display("error counts: testbench %0d, assertions %0d", errors, fails);
        if (errors == 0 && fails == 0)
        begin
            $display("Everything OK");
        end
        else
        begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* all.f */
common/conv_pkg.sv
design/capture_lane.sv
design/dac_pair_packer.sv
design/rf_loopback_top.sv
verif/tb_clock.sv
verif/rf_loopback_properties.sv
verif/rf_loopback_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the loopback testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module rf_loopback_tb -f all.f -o rf_loopback_sim \
    && ./obj_dir/rf_loopback_sim +verilator+error+limit+1000 | tee /dev/stderr \
        | grep -x "Everything OK" > /dev/null \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }
